/* ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// data path width, fixed for rv32
`define XLEN 32

// one quotient bit is resolved per active divider cycle
`define DIV_CYCLES 32

`endif

/* ex_pkg.sv */
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10  // lui
    } alu_op_e;

    // multiply reading of the mul/div code, low bits of funct3
    typedef enum logic [1:0] {
        MD_MUL    = 2'd0,
        MD_MULH   = 2'd1,
        MD_MULHSU = 2'd2,
        MD_MULHU  = 2'd3
    } md_op_e;

    // divide reading of the same two bits
    typedef enum logic [1:0] {
        MD_DIV  = 2'd0,
        MD_DIVU = 2'd1,
        MD_REM  = 2'd2,
        MD_REMU = 2'd3
    } div_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        alu_src;  // b from imm
        logic        op1_pc;   // a from pc
        logic        jump;
        logic        branch;
        logic        jalr;
        logic [2:0]  funct3;
        logic        mul_en;
        logic        div_en;
        md_op_e      md_op;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] rd1;
        logic [`XLEN-1:0] rd2;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
    } ex_data_t;

    typedef struct packed {
        fwd_sel_e         fwd_rs1;
        fwd_sel_e         fwd_rs2;
        logic [`XLEN-1:0] result_w;
        logic [`XLEN-1:0] ex_out_m;
    } ex_fwd_t;

    typedef struct packed {
        logic [`XLEN-1:0] ex_out;
        logic [`XLEN-1:0] write_data;
        logic [`XLEN-1:0] pc_target;
        logic             pc_src;
        logic             zero;
    } ex_out_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module alu import ex_pkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_e          op,
    input  logic [2:0]       funct3,
    output logic [`XLEN-1:0] result,
    output logic             cond
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt;  // sign fill
            end
            ALU_SLT: begin
                result = {{(`XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                result = {{(`XLEN-1){1'b0}}, lt_u};
            end
            ALU_PASS_B: begin
                result = b;  // lui, imm already shifted
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch test decoded from funct3
    always_comb begin
        case (funct3)
            3'b000: begin
                cond = eq;  // beq
            end
            3'b001: begin
                cond = ~eq;  // bne
            end
            3'b100: begin
                cond = lt_s;  // blt
            end
            3'b101: begin
                cond = ~lt_s;  // bge
            end
            3'b110: begin
                cond = lt_u;  // bltu
            end
            3'b111: begin
                cond = ~lt_u;  // bgeu
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module muldiv import ex_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  md_op_e           op,
    input  logic             mul_en,
    input  logic             div_en,
    input  logic             cache_stall,
    output logic [`XLEN-1:0] result,
    output logic             busy
);

    localparam int CNT_W = $clog2(`DIV_CYCLES);

    // multiplier
    logic                        a_sgn_m;
    logic                        b_sgn_m;
    logic signed [`XLEN:0]       mul_a;
    logic signed [`XLEN:0]       mul_b;
    logic signed [2*`XLEN+1:0]   prod;
    logic [`XLEN-1:0]            mul_res;

    assign a_sgn_m = (op == MD_MULH) || (op == MD_MULHSU);
    assign b_sgn_m = (op == MD_MULH);
    assign mul_a   = {a_sgn_m & a[`XLEN-1], a};  // 33-bit extension per signedness
    assign mul_b   = {b_sgn_m & b[`XLEN-1], b};
    assign prod    = mul_a * mul_b;
    assign mul_res = (op == MD_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];

    // divider
    div_op_e          dop;
    logic             sgn;
    logic             a_neg;
    logic             b_neg;
    logic             start;
    logic             done;
    logic [CNT_W-1:0] cnt;
    logic             last;
    logic [`XLEN-1:0] quo_q;
    logic [`XLEN-1:0] rem_q;
    logic [`XLEN-1:0] dvsr_q;
    logic             neg_q_q;
    logic             neg_r_q;
    logic             rem_sel_q;
    logic             zero_q;
    logic             ovf_q;
    logic [`XLEN:0]   r_shift;
    logic [`XLEN:0]   r_trial;
    logic [`XLEN-1:0] r_next;
    logic [`XLEN-1:0] q_next;
    logic [`XLEN-1:0] q_fix;
    logic [`XLEN-1:0] r_fix;
    logic [`XLEN-1:0] div_res_q;

    assign dop   = div_op_e'(op);
    assign sgn   = (dop == MD_DIV) || (dop == MD_REM);
    assign a_neg = sgn & a[`XLEN-1];
    assign b_neg = sgn & b[`XLEN-1];
    assign start = div_en & ~busy & ~done & ~cache_stall;
    assign last  = (cnt == CNT_W'(`DIV_CYCLES - 1));

    // one restoring step, trial subtract of the divisor
    assign r_shift = {rem_q, quo_q[`XLEN-1]};
    assign r_trial = r_shift - {1'b0, dvsr_q};
    assign r_next  = r_trial[`XLEN] ? r_shift[`XLEN-1:0] : r_trial[`XLEN-1:0];
    assign q_next  = {quo_q[`XLEN-2:0], ~r_trial[`XLEN]};

    always_comb begin
        q_fix = neg_q_q ? -q_next : q_next;
        r_fix = neg_r_q ? -r_next : r_next;  // by zero gives the dividend back here
        if (zero_q) begin
            q_fix = '1;
        end else if (ovf_q) begin
            q_fix = {1'b1, {(`XLEN-1){1'b0}}};  // most negative value
            r_fix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            if (!cache_stall) begin  // stalled cycles freeze the iteration
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (!div_en) begin
            done <= 1'b0;  // result released, ready for next start
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= a_neg ? -a : a;
            dvsr_q    <= b_neg ? -b : b;
            rem_q     <= '0;
            neg_q_q   <= a_neg ^ b_neg;
            neg_r_q   <= a_neg;
            rem_sel_q <= (dop == MD_REM) || (dop == MD_REMU);
            zero_q    <= (b == '0);
            ovf_q     <= sgn && (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);
        end else if (busy && !cache_stall) begin
            quo_q <= q_next;
            rem_q <= r_next;
            if (last) begin
                div_res_q <= rem_sel_q ? r_fix : q_fix;
            end
        end
    end

    assign result = mul_en ? mul_res : div_res_q;

endmodule

`default_nettype wire

/* execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module execute import ex_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  ex_ctrl_t ctrl,
    input  ex_data_t data,
    input  ex_fwd_t  fwd,
    input  logic     cache_stall,
    output ex_out_t  res,
    output logic     div_busy
);

    logic [`XLEN-1:0] rs1_fwd;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] alu_res;
    logic             cond;
    logic [`XLEN-1:0] md_res;
    logic [`XLEN-1:0] pc_imm;

    // pick the newest copy of a register operand
    function automatic logic [`XLEN-1:0] fwd_pick(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_val,
        input ex_fwd_t          f
    );
        case (sel)
            FWD_WB: begin
                return f.result_w;
            end
            FWD_MEM: begin
                return f.ex_out_m;
            end
            default: begin
                return reg_val;
            end
        endcase
    endfunction

    assign rs1_fwd = fwd_pick(fwd.fwd_rs1, data.rd1, fwd);
    assign rs2_fwd = fwd_pick(fwd.fwd_rs2, data.rd2, fwd);

    assign src_a = ctrl.op1_pc ? data.pc : rs1_fwd;  // auipc / jal
    assign src_b = ctrl.alu_src ? data.imm : rs2_fwd;

    alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (ctrl.alu_op),
        .funct3 (ctrl.funct3),
        .result (alu_res),
        .cond   (cond)
    );

    muldiv u_muldiv (
        .clk         (clk),
        .reset       (reset),
        .a           (src_a),
        .b           (src_b),
        .op          (ctrl.md_op),
        .mul_en      (ctrl.mul_en),
        .div_en      (ctrl.div_en),
        .cache_stall (cache_stall),
        .result      (md_res),
        .busy        (div_busy)
    );

    assign pc_imm = data.pc + data.imm;

    always_comb begin
        res.ex_out     = (ctrl.mul_en | ctrl.div_en) ? md_res : alu_res;
        res.write_data = rs2_fwd;
        // jalr target comes out of the alu as rs1 + imm
        res.pc_target  = ctrl.jalr ? {alu_res[`XLEN-1:1], 1'b0} : pc_imm;
        res.pc_src     = ctrl.jump | (ctrl.branch & cond);
        res.zero       = cond;
    end

endmodule

`default_nettype wire

/* tb_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module tb_execute import ex_pkg::*; ();

    localparam int MAX_DIV_WAIT = 4 * `DIV_CYCLES;

    logic     clk;
    logic     reset;
    ex_ctrl_t ctrl;
    ex_data_t data;
    ex_fwd_t  fwd;
    logic     cache_stall;
    ex_out_t  res;
    logic     div_busy;

    ex_ctrl_t    ctrl_v[$];
    ex_data_t    data_v[$];
    ex_fwd_t     fwd_v[$];
    ex_out_t     exp_v[$];  // zero comes from pc_src on branches
    logic [31:0] lfsr = 32'h05c0_3782;
    int          vec_idx = -1;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    execute dut (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .data        (data),
        .fwd         (fwd),
        .cache_stall (cache_stall),
        .res         (res),
        .div_busy    (div_busy)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_stall_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t vector %0d %s exp=%h got=%h", $time, vec_idx, name, exp, got);
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f[22];
        fd = $fopen("ex_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open ex_input.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                        f[21]);
            if (n != 22) begin
                errors++;
                $display("vector line has %0d fields instead of 22: %s", n, line);
            end else begin
                ctrl_v.push_back({f[0][3:0], f[1][0], f[2][0], f[3][0], f[4][0], f[5][0],
                                  f[6][2:0], f[7][0], f[8][0], f[9][1:0]});
                data_v.push_back({f[10], f[11], f[12], f[13]});
                fwd_v.push_back({f[14][1:0], f[15][1:0], f[16], f[17]});
                exp_v.push_back({f[18], f[19], f[20], f[21][0], 1'b0});
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        ctrl        <= ctrl_v[i];
        data        <= data_v[i];
        fwd         <= fwd_v[i];
        cache_stall <= 1'b0;
    endtask

    task automatic check_outputs(input int i);
        compare_word("res.ex_out", exp_v[i].ex_out, res.ex_out);
        compare_word("res.write_data", exp_v[i].write_data, res.write_data);
        compare_word("res.pc_target", exp_v[i].pc_target, res.pc_target);
        compare_word("res.pc_src", exp_v[i].pc_src, res.pc_src);
        if (ctrl_v[i].branch && !ctrl_v[i].jump) begin
            compare_word("res.zero", exp_v[i].pc_src, res.zero);  // branch outcome
        end
    endtask

    task automatic run_divide(input int i);
        int          busy_edges;
        int          stalls;
        logic [31:0] held;
        logic        stall_bit;
        @(posedge clk);  // start edge
        busy_edges = 0;
        stalls = 0;
        held = res.ex_out;
        take_stall_bit(stall_bit);
        cache_stall <= stall_bit;
        @(posedge clk);
        while (div_busy && busy_edges < MAX_DIV_WAIT) begin
            busy_edges++;
            if (cache_stall) begin
                stalls++;  // frozen edge
            end
            compare_word("res.ex_out while busy", held, res.ex_out);
            take_stall_bit(stall_bit);
            cache_stall <= stall_bit;
            @(posedge clk);
        end
        cache_stall <= 1'b0;
        if (div_busy) begin
            errors++;
            $display("divide of vector %0d still busy after %0d cycles", i, MAX_DIV_WAIT);
        end else begin
            compare_word("div_busy fall cycle", `DIV_CYCLES + stalls, busy_edges);
            check_outputs(i);
        end
        ctrl.div_en <= 1'b0;  // lets the divider take the next start
        @(posedge clk);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        ctrl        = '0;
        data        = '0;
        fwd         = '0;
        cache_stall = 1'b0;
        read_vectors();
        cycle_limit = ctrl_v.size() * (2 * `DIV_CYCLES + 4) + 20;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        compare_word("div_busy", 32'd0, div_busy);
        for (int i = 0; i < ctrl_v.size(); i++) begin
            vec_idx = i;
            drive_vector(i);
            if (ctrl_v[i].div_en) begin
                run_divide(i);
            end else begin
                @(posedge clk);
                check_outputs(i);
            end
        end
        $display("tb_execute: %0d vectors, %0d checks, %0d errors", ctrl_v.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ex_input.txt */
# alu_op alu_src op1_pc jump branch jalr funct3 mul_en div_en md_op rd1 rd2 pc imm (hex)
# fwd_rs1 fwd_rs2 result_w ex_out_m, then expected ex_out write_data pc_target pc_src
0 0 0 0 0 0 0 0 0 0  5 3 0 0  0 0 0 0  8 3 0 0
0 0 0 0 0 0 0 0 0 0  ffffffff 1 0 0  0 0 0 0  0 1 0 0
1 0 0 0 0 0 0 0 0 0  3 5 0 0  0 0 0 0  fffffffe 5 0 0
2 0 0 0 0 0 0 0 0 0  f0f0f0f0 ff00ff00 0 0  0 0 0 0  f000f000 ff00ff00 0 0
3 0 0 0 0 0 0 0 0 0  f0f0f0f0 0f0f0000 0 0  0 0 0 0  fffff0f0 0f0f0000 0 0
4 0 0 0 0 0 0 0 0 0  aaaaaaaa ffff0000 0 0  0 0 0 0  5555aaaa ffff0000 0 0
5 0 0 0 0 0 0 0 0 0  1 1f 0 0  0 0 0 0  80000000 1f 0 0
5 0 0 0 0 0 0 0 0 0  3 25 0 0  0 0 0 0  60 25 0 0
6 0 0 0 0 0 0 0 0 0  80000000 4 0 0  0 0 0 0  08000000 4 0 0
7 0 0 0 0 0 0 0 0 0  80000000 4 0 0  0 0 0 0  f8000000 4 0 0
8 0 0 0 0 0 0 0 0 0  ffffffff 1 0 0  0 0 0 0  1 1 0 0
9 0 0 0 0 0 0 0 0 0  ffffffff 1 0 0  0 0 0 0  0 1 0 0
9 0 0 0 0 0 0 0 0 0  1 ffffffff 0 0  0 0 0 0  1 ffffffff 0 0
0 1 0 0 0 0 0 0 0 0  10 0 0 fffffff0  0 0 0 0  0 0 fffffff0 0
a 1 0 0 0 0 0 0 0 0  dead 0 0 12345000  0 0 0 0  12345000 0 12345000 0
8 1 0 0 0 0 0 0 0 0  fffffffb 0 0 fffffffe  0 0 0 0  1 0 fffffffe 0
7 1 0 0 0 0 0 0 0 0  f0000000 0 0 404  0 0 0 0  ff000000 0 404 0
0 0 0 0 0 0 0 0 0 0  1 2 0 0  1 0 100 200  102 2 0 0
0 0 0 0 0 0 0 0 0 0  1 2 0 0  2 0 100 200  202 2 0 0
0 0 0 0 0 0 0 0 0 0  1 2 0 0  0 1 100 200  101 100 0 0
0 0 0 0 0 0 0 0 0 0  1 2 0 0  0 2 100 200  201 200 0 0
1 0 0 0 0 0 0 0 0 0  1 2 0 0  2 1 100 200  100 100 0 0
0 1 0 0 0 0 0 0 0 0  1000 2 0 8  0 2 100 cafe  1008 cafe 8 0
0 1 1 0 0 0 0 0 0 0  ffff 0 400 2000  1 0 100 0  2400 0 2400 0
1 0 0 0 1 0 0 0 0 0  5 5 100 20  0 0 0 0  0 5 120 1
1 0 0 0 1 0 0 0 0 0  5 6 100 20  0 0 0 0  ffffffff 6 120 0
1 0 0 0 1 0 1 0 0 0  5 6 100 20  0 0 0 0  ffffffff 6 120 1
1 0 0 0 1 0 1 0 0 0  5 5 100 20  0 0 0 0  0 5 120 0
1 0 0 0 1 0 4 0 0 0  ffffffff 1 100 20  0 0 0 0  fffffffe 1 120 1
1 0 0 0 1 0 4 0 0 0  1 ffffffff 100 20  0 0 0 0  2 ffffffff 120 0
1 0 0 0 1 0 5 0 0 0  1 ffffffff 100 20  0 0 0 0  2 ffffffff 120 1
1 0 0 0 1 0 5 0 0 0  ffffffff 1 100 20  0 0 0 0  fffffffe 1 120 0
1 0 0 0 1 0 5 0 0 0  7 7 200 fffffff0  0 0 0 0  0 7 1f0 1
1 0 0 0 1 0 6 0 0 0  1 ffffffff 100 20  0 0 0 0  2 ffffffff 120 1
1 0 0 0 1 0 6 0 0 0  ffffffff 1 100 20  0 0 0 0  fffffffe 1 120 0
1 0 0 0 1 0 7 0 0 0  ffffffff 1 100 20  0 0 0 0  fffffffe 1 120 1
1 0 0 0 1 0 7 0 0 0  1 ffffffff 200 fffffff0  0 0 0 0  2 ffffffff 1f0 0
0 1 1 1 0 0 0 0 0 0  0 0 1000 800  0 0 0 0  1800 0 1800 1
0 1 0 1 0 1 0 0 0 0  2001 0 300 4  0 0 0 0  2005 0 2004 1
0 1 0 1 0 1 0 0 0 0  3000 0 300 7  2 0 0 4000  4007 0 4006 1
0 0 0 0 0 0 0 1 0 0  7fffffff 7fffffff 0 0  0 0 0 0  1 7fffffff 0 0
0 0 0 0 0 0 0 1 0 1  80000000 80000000 0 0  0 0 0 0  40000000 80000000 0 0
0 0 0 0 0 0 0 1 0 2  ffffffff ffffffff 0 0  0 0 0 0  ffffffff ffffffff 0 0
0 0 0 0 0 0 0 1 0 2  7fffffff ffffffff 0 0  0 0 0 0  7ffffffe ffffffff 0 0
0 0 0 0 0 0 0 1 0 3  ffffffff ffffffff 0 0  0 0 0 0  fffffffe ffffffff 0 0
0 0 0 0 0 0 0 1 0 3  80000000 4 0 0  0 0 0 0  2 4 0 0
0 0 0 0 0 0 0 0 1 0  fffffff9 2 0 0  0 0 0 0  fffffffd 2 0 0
0 0 0 0 0 0 0 0 1 2  fffffff9 2 0 0  0 0 0 0  ffffffff 2 0 0
0 0 0 0 0 0 0 0 1 1  fffffff9 2 0 0  0 0 0 0  7ffffffc 2 0 0
0 0 0 0 0 0 0 0 1 3  fffffff9 2 0 0  0 0 0 0  1 2 0 0
0 0 0 0 0 0 0 0 1 0  1234 0 0 0  0 0 0 0  ffffffff 0 0 0
0 0 0 0 0 0 0 0 1 2  fffffff9 0 0 0  0 0 0 0  fffffff9 0 0 0
0 0 0 0 0 0 0 0 1 0  80000000 ffffffff 0 0  0 0 0 0  80000000 ffffffff 0 0
0 0 0 0 0 0 0 0 1 2  80000000 ffffffff 0 0  0 0 0 0  0 ffffffff 0 0
0 0 0 0 0 0 0 0 1 0  64 fffffffd 0 0  0 0 0 0  ffffffdf fffffffd 0 0

/* tb.f */
+incdir+.
ex_pkg.sv
alu.sv
muldiv.sv
execute.sv
tb_execute.sv
